/* ping_cfg_pkg.sv */
// ping subsystem configuration
// channel counts, counter and LFSR widths, and the vector types that
// carry these sizes between the timer, the channels and the status block

`default_nettype none

package ping_cfg_pkg;

  ////////////////////////////////////////
  // channel counts
  ////////////////////////////////////////

  // alert channels occupy the low channel indices, escalation channels the high ones
  localparam int unsigned NAlerts = 4;
  localparam int unsigned NEscSev = 4;
  localparam int unsigned NChan   = NAlerts + NEscSev;

  ////////////////////////////////////////
  // widths
  ////////////////////////////////////////

  localparam int unsigned PingCntDw = 16;
  localparam int unsigned LfsrDw    = 32;
  localparam int unsigned AlertIdDw = 2;
  localparam int unsigned EscIdDw   = 2;

  // a cycle count for waits and timeouts
  typedef logic [PingCntDw-1:0] ping_cnt_t;
  // LFSR state, also the width of one entropy word
  typedef logic [LfsrDw-1:0]    lfsr_t;
  typedef logic [AlertIdDw-1:0] alert_id_t;
  typedef logic [EscIdDw-1:0]   esc_id_t;
  // one bit per channel of the given kind
  typedef logic [NAlerts-1:0]   alert_vec_t;
  typedef logic [NEscSev-1:0]   esc_vec_t;

endpackage

`default_nettype wire

/* ping_fsm_pkg.sv */
// ping timer state machine definitions
// sparse state encoding, LFSR reset seed and fixed timer constants

`default_nettype none

package ping_fsm_pkg;

  ////////////////////////////////////////
  // state encoding
  ////////////////////////////////////////

  // every pair of codes differs in at least five bits, so a single
  // upset cannot move the machine into another legal state
  typedef enum logic [8:0] {
    InitSt      = 9'b011001011,
    AlertWaitSt = 9'b110000000,
    AlertPingSt = 9'b101110001,
    EscWaitSt   = 9'b010110110,
    EscPingSt   = 9'b000011101,
    FsmErrorSt  = 9'b101101110
  } ping_state_e;

  ////////////////////////////////////////
  // timer constants
  ////////////////////////////////////////

  // both LFSR copies start here, must be nonzero
  localparam ping_cfg_pkg::lfsr_t LfsrSeedDefault = 32'h6b3e_91d5;
  // ORed into each drawn wait to keep pings at least a few cycles apart
  localparam ping_cfg_pkg::ping_cnt_t MinWaitOr = 16'h0004;
  // the reseed timer is this many bits wider than the wait counter
  localparam int unsigned ReseedExtraBits = 3;

endpackage

`default_nettype wire

/* ping_lfsr.sv */
// redundant pseudo random source for the ping timer
// two Galois LFSRs step in lockstep and fold in entropy words,
// any difference between the copies is flagged as an error

`timescale 1ns/1ns
`default_nettype none

module ping_lfsr (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic                en_i,
  input  ping_cfg_pkg::lfsr_t entropy_i,
  output ping_cfg_pkg::lfsr_t state_o,
  output logic                err_o
);
  import ping_cfg_pkg::*;
  import ping_fsm_pkg::*;

  lfsr_t lfsr_q [2];

  ////////////////////////////////////////
  // lockstep LFSR copies
  ////////////////////////////////////////

  for (genvar k = 0; k < 2; k++) begin : gen_lfsr
    lfsr_t lfsr_step;
    lfsr_t lfsr_d;

    // right shifting Galois form of x^32 + x^22 + x^2 + x + 1
    assign lfsr_step = {1'b0, lfsr_q[k][LfsrDw-1:1]} ^
                       (lfsr_q[k][0] ? lfsr_t'(32'h8020_0003) : '0);

    // entropy is zero outside a reseed, so the XOR only acts on a transfer
    assign lfsr_d = lfsr_step ^ entropy_i;

    always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
        lfsr_q[k] <= LfsrSeedDefault;
      end else if (en_i) begin
        // an unlucky entropy word could cancel the state, fall back to the seed
        if (lfsr_d == '0) begin
          lfsr_q[k] <= LfsrSeedDefault;
        end else begin
          lfsr_q[k] <= lfsr_d;
        end
      end
    end
  end

  // only copy zero feeds the timer, copy one exists purely as a check
  assign state_o = lfsr_q[0];
  assign err_o   = (lfsr_q[0] != lfsr_q[1]);

  ////////////////////////////////////////
  // assertions
  ////////////////////////////////////////

  // the all zero state would lock up the sequence for good
  lfsr_nonzero_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (lfsr_q[0] != '0) && (lfsr_q[1] != '0));

endmodule

`default_nettype wire

/* ping_timer.sv */
// ping timer
// draws a random alert channel and a random pause from the LFSR, pings
// alert and escalation channels in turn and flags missing answers,
// counters and LFSR are duplicated and any disagreement is terminal

`timescale 1ns/1ns
`default_nettype none

module ping_timer (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  logic                     en_i,
  output logic                     edn_req_o,
  input  logic                     edn_ack_i,
  input  ping_cfg_pkg::lfsr_t      edn_data_i,
  input  ping_cfg_pkg::alert_vec_t alert_ping_en_i,
  input  ping_cfg_pkg::ping_cnt_t  ping_timeout_cyc_i,
  input  ping_cfg_pkg::ping_cnt_t  wait_cyc_mask_i,
  output ping_cfg_pkg::alert_vec_t alert_ping_req_o,
  output ping_cfg_pkg::esc_vec_t   esc_ping_req_o,
  input  ping_cfg_pkg::alert_vec_t alert_ping_ok_i,
  input  ping_cfg_pkg::esc_vec_t   esc_ping_ok_i,
  output logic                     alert_fail_o,
  output logic                     esc_fail_o,
  output logic                     fsm_err_o
);
  import ping_cfg_pkg::*;
  import ping_fsm_pkg::*;

  logic [PingCntDw+ReseedExtraBits-1:0] reseed_timer_q;
  logic        reseed_en;
  lfsr_t       entropy;
  lfsr_t       lfsr_state;
  logic        lfsr_en;
  logic        lfsr_err;
  alert_id_t   id_to_ping;
  logic        id_vld;
  ping_cnt_t   wait_cyc;
  ping_cnt_t   cnt_q [2];
  esc_id_t     esc_cnt_q [2];
  logic        wait_cnt_load;
  logic        timeout_cnt_load;
  logic        esc_cnt_en;
  logic        timer_expired;
  logic        alert_ping_en;
  logic        esc_ping_en;
  ping_state_e state_d;
  ping_state_e state_q;

  ////////////////////////////////////////
  // reseed timer
  ////////////////////////////////////////

  // the request stays up for as long as the timer sits at zero
  assign edn_req_o = (reseed_timer_q == '0);
  assign reseed_en = edn_req_o & edn_ack_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      reseed_timer_q <= '0;
    end else if (!edn_req_o) begin
      reseed_timer_q <= reseed_timer_q - 1'b1;
    end else if (edn_ack_i) begin
      // roughly every eighth ping on average gets fresh entropy
      reseed_timer_q <= {wait_cyc_mask_i, {ReseedExtraBits{1'b1}}};
    end
  end

  ////////////////////////////////////////
  // random draws
  ////////////////////////////////////////

  assign entropy = reseed_en ? edn_data_i : '0;
  // advance on every counter load so each ping gets a new draw
  assign lfsr_en = reseed_en | wait_cnt_load | timeout_cnt_load;

  ping_lfsr u_ping_lfsr (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .en_i      (lfsr_en),
    .entropy_i (entropy),
    .state_o   (lfsr_state),
    .err_o     (lfsr_err)
  );

  // the bits above the wait field pick the alert channel
  // the pick is taken when the ping state is entered and held until it is left
  // so that a reseed in the middle of a ping cannot move the request
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      id_to_ping <= '0;
    end else if (timeout_cnt_load) begin
      id_to_ping <= lfsr_state[PingCntDw +: AlertIdDw];
    end
  end

  assign id_vld = alert_ping_en_i[id_to_ping];

  // the mask shortens waits in simulation, the OR keeps a minimum spacing
  assign wait_cyc = (lfsr_state[PingCntDw-1:0] | MinWaitOr) & wait_cyc_mask_i;

  ////////////////////////////////////////
  // duplicated counters
  ////////////////////////////////////////

  assign timer_expired = (cnt_q[0] == '0);

  for (genvar k = 0; k < 2; k++) begin : gen_dup_cnt
    always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
        cnt_q[k]     <= '0;
        esc_cnt_q[k] <= '0;
      end else begin
        if (wait_cnt_load) begin
          cnt_q[k] <= wait_cyc;
        end else if (timeout_cnt_load) begin
          cnt_q[k] <= ping_timeout_cyc_i;
        end else if (cnt_q[k] != '0) begin
          cnt_q[k] <= cnt_q[k] - 1'b1;
        end
        // escalation channels go round robin and not at random
        if (esc_cnt_en) begin
          if (esc_cnt_q[k] == esc_id_t'(NEscSev - 1)) begin
            esc_cnt_q[k] <= '0;
          end else begin
            esc_cnt_q[k] <= esc_cnt_q[k] + 1'b1;
          end
        end
      end
    end
  end

  ////////////////////////////////////////
  // ping state machine
  ////////////////////////////////////////

  assign alert_ping_req_o = alert_vec_t'(alert_ping_en) << id_to_ping;
  assign esc_ping_req_o   = esc_vec_t'(esc_ping_en) << esc_cnt_q[0];
  assign fsm_err_o        = (state_q == FsmErrorSt);

  always_comb begin
    state_d          = state_q;
    wait_cnt_load    = 1'b0;
    timeout_cnt_load = 1'b0;
    esc_cnt_en       = 1'b0;
    alert_ping_en    = 1'b0;
    esc_ping_en      = 1'b0;
    alert_fail_o     = 1'b0;
    esc_fail_o       = 1'b0;

    unique case (state_q)
      // idle until enabled, never entered again afterwards
      InitSt: begin
        if (en_i) begin
          state_d       = AlertWaitSt;
          wait_cnt_load = 1'b1;
        end
      end
      AlertWaitSt: begin
        if (timer_expired) begin
          state_d          = AlertPingSt;
          timeout_cnt_load = 1'b1;
        end
      end
      // a disabled channel is skipped after one cycle without a request
      AlertPingSt: begin
        alert_ping_en = id_vld;
        if (timer_expired || |(alert_ping_ok_i & alert_ping_req_o) || !id_vld) begin
          state_d       = EscWaitSt;
          wait_cnt_load = 1'b1;
          alert_fail_o  = timer_expired & id_vld;
        end
      end
      EscWaitSt: begin
        if (timer_expired) begin
          state_d          = EscPingSt;
          timeout_cnt_load = 1'b1;
        end
      end
      EscPingSt: begin
        esc_ping_en = 1'b1;
        if (timer_expired || |(esc_ping_ok_i & esc_ping_req_o)) begin
          state_d       = AlertWaitSt;
          wait_cnt_load = 1'b1;
          esc_cnt_en    = 1'b1;
          esc_fail_o    = timer_expired;
        end
      end
      // terminal, only a reset leaves it
      FsmErrorSt: begin
        state_d = FsmErrorSt;
      end
      default: begin
        state_d = FsmErrorSt;
      end
    endcase

    // disagreeing copies mean the logic was disturbed
    if (lfsr_err || (cnt_q[0] != cnt_q[1]) || (esc_cnt_q[0] != esc_cnt_q[1])) begin
      state_d = FsmErrorSt;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= InitSt;
    end else begin
      state_q <= state_d;
    end
  end

  ////////////////////////////////////////
  // assertions
  ////////////////////////////////////////

  // at most one channel of either kind is pinged at any time
  ping_req_onehot0_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    $onehot0({alert_ping_req_o, esc_ping_req_o}));

  // the round robin index always points at a real escalation channel
  esc_ping_onehot_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (state_q == EscPingSt) |-> $onehot(esc_ping_req_o));

endmodule

`default_nettype wire

/* ping_chan.sv */
// ping channel
// turns a ping request level into a one cycle ping strobe and sorts
// the acknowledges that come back into expected and spurious ones

`timescale 1ns/1ns
`default_nettype none

module ping_chan (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic req_i,
  input  logic ack_i,
  output logic ping_o,
  output logic ok_o,
  output logic spurious_o
);

  logic req_q;
  logic req_rise;
  logic pending_q;

  // a new ping starts on the rising edge of the request
  assign req_rise = req_i & ~req_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      req_q      <= 1'b0;
      ping_o     <= 1'b0;
      pending_q  <= 1'b0;
      ok_o       <= 1'b0;
      spurious_o <= 1'b0;
    end else begin
      req_q  <= req_i;
      ping_o <= req_rise;

      // the ping stays outstanding until answered or withdrawn by the timer
      if (req_rise) begin
        pending_q <= 1'b1;
      end else if (ack_i || !req_i) begin
        pending_q <= 1'b0;
      end

      // only an answer to an outstanding ping counts as ok
      ok_o       <= ack_i & pending_q;
      spurious_o <= ack_i & ~pending_q;
    end
  end

  ////////////////////////////////////////
  // assertions
  ////////////////////////////////////////

  // the responder answers with a single cycle strobe and no back-pressure
  ack_strobe_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    ack_i |=> !ack_i);

endmodule

`default_nettype wire

/* ping_fail_status.sv */
// ping failure status
// collects timeouts, spurious acknowledges and the timer error into
// sticky flags, the error flag survives a clear

`timescale 1ns/1ns
`default_nettype none

module ping_fail_status (
  input  logic                           clk_i,
  input  logic                           rst_ni,
  input  logic                           clr_i,
  input  logic                           alert_fail_i,
  input  logic                           esc_fail_i,
  input  logic                           fsm_err_i,
  input  logic [ping_cfg_pkg::NChan-1:0] spurious_i,
  output logic                           alert_fail_o,
  output logic                           esc_fail_o,
  output logic                           spurious_o,
  output logic                           fsm_err_o
);

  logic spurious_any;

  // any channel may report an unexpected acknowledge
  assign spurious_any = |spurious_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      alert_fail_o <= 1'b0;
      esc_fail_o   <= 1'b0;
      spurious_o   <= 1'b0;
      fsm_err_o    <= 1'b0;
    end else begin
      // an event in the clear cycle itself is still recorded
      alert_fail_o <= (alert_fail_o & ~clr_i) | alert_fail_i;
      esc_fail_o   <= (esc_fail_o & ~clr_i) | esc_fail_i;
      spurious_o   <= (spurious_o & ~clr_i) | spurious_any;
      // the timer error is terminal so its flag ignores the clear
      fsm_err_o    <= fsm_err_o | fsm_err_i;
    end
  end

  ////////////////////////////////////////
  // assertions
  ////////////////////////////////////////

  // the timer never leaves its error state so its error input never drops again
  fsm_err_terminal_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    fsm_err_i |=> fsm_err_i);

endmodule

`default_nettype wire

/* ping_subsys_top.sv */
// ping liveness checker top level
// the timer requests pings, eight channels talk to the responders and
// the status block gathers all failures

`timescale 1ns/1ns
`default_nettype none

module ping_subsys_top (
  input  logic                           clk_i,
  input  logic                           rst_ni,
  input  logic                           en_i,
  input  logic                           clr_i,
  input  logic                           edn_ack_i,
  input  ping_cfg_pkg::lfsr_t            edn_data_i,
  input  ping_cfg_pkg::alert_vec_t       alert_ping_en_i,
  input  ping_cfg_pkg::ping_cnt_t        ping_timeout_cyc_i,
  input  ping_cfg_pkg::ping_cnt_t        wait_cyc_mask_i,
  input  logic [ping_cfg_pkg::NChan-1:0] ack_i,
  output logic                           edn_req_o,
  output logic [ping_cfg_pkg::NChan-1:0] ping_o,
  output logic                           alert_fail_o,
  output logic                           esc_fail_o,
  output logic                           spurious_o,
  output logic                           fsm_err_o
);
  import ping_cfg_pkg::*;

  alert_vec_t       alert_ping_req;
  alert_vec_t       alert_ping_ok;
  esc_vec_t         esc_ping_req;
  esc_vec_t         esc_ping_ok;
  logic [NChan-1:0] chan_req;
  logic [NChan-1:0] chan_ok;
  logic [NChan-1:0] chan_spurious;
  logic             alert_fail;
  logic             esc_fail;
  logic             fsm_err;

  ping_timer u_ping_timer (
    .clk_i              (clk_i),
    .rst_ni             (rst_ni),
    .en_i               (en_i),
    .edn_req_o          (edn_req_o),
    .edn_ack_i          (edn_ack_i),
    .edn_data_i         (edn_data_i),
    .alert_ping_en_i    (alert_ping_en_i),
    .ping_timeout_cyc_i (ping_timeout_cyc_i),
    .wait_cyc_mask_i    (wait_cyc_mask_i),
    .alert_ping_req_o   (alert_ping_req),
    .esc_ping_req_o     (esc_ping_req),
    .alert_ping_ok_i    (alert_ping_ok),
    .esc_ping_ok_i      (esc_ping_ok),
    .alert_fail_o       (alert_fail),
    .esc_fail_o         (esc_fail),
    .fsm_err_o          (fsm_err)
  );

  // alerts sit in the low channel bits, escalations above them
  assign chan_req      = {esc_ping_req, alert_ping_req};
  assign alert_ping_ok = chan_ok[NAlerts-1:0];
  assign esc_ping_ok   = chan_ok[NChan-1:NAlerts];

  for (genvar i = 0; i < NChan; i++) begin : gen_chan
    ping_chan u_ping_chan (
      .clk_i      (clk_i),
      .rst_ni     (rst_ni),
      .req_i      (chan_req[i]),
      .ack_i      (ack_i[i]),
      .ping_o     (ping_o[i]),
      .ok_o       (chan_ok[i]),
      .spurious_o (chan_spurious[i])
    );
  end

  ping_fail_status u_ping_fail_status (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .clr_i        (clr_i),
    .alert_fail_i (alert_fail),
    .esc_fail_i   (esc_fail),
    .fsm_err_i    (fsm_err),
    .spurious_i   (chan_spurious),
    .alert_fail_o (alert_fail_o),
    .esc_fail_o   (esc_fail_o),
    .spurious_o   (spurious_o),
    .fsm_err_o    (fsm_err_o)
  );

endmodule

`default_nettype wire

/* tb_ping_subsys.sv */
// testbench for the ping liveness checker
// directed tests with responder models for the eight channels and the
// entropy port, a ping monitor and a watchdog

`timescale 1ns/1ns
`default_nettype none

module tb_ping_subsys;
  import ping_cfg_pkg::*;

  localparam int Period     = 100;
  localparam int Timeout    = 20;
  // one ping round is at most a masked wait plus the timeout
  localparam int PingCycles = 16 + Timeout;
  localparam int TotalPings = 12 + 16 + 4 + 4 + 4;
  localparam int WatchdogCycles = 2 * TotalPings * PingCycles + 400;

  logic             clk_i;
  logic             rst_ni;
  logic             en_i;
  logic             clr_i;
  logic             edn_ack_i = 1'b0;
  lfsr_t            edn_data_i = '0;
  alert_vec_t       alert_ping_en_i;
  ping_cnt_t        ping_timeout_cyc_i;
  ping_cnt_t        wait_cyc_mask_i;
  logic [NChan-1:0] ack_i;
  logic             edn_req_o;
  logic [NChan-1:0] ping_o;
  logic             alert_fail_o;
  logic             esc_fail_o;
  logic             spurious_o;
  logic             fsm_err_o;

  logic [NChan-1:0] resp_ack = '0;
  logic [NChan-1:0] inject_ack;
  logic [NChan-1:0] resp_on;
  int               resp_dly;
  int               resp_cnt [NChan];
  logic             edn_en;
  int               seed;
  int               errors;
  int               checks;
  int               tests;
  // channel index of every observed ping strobe, oldest first
  int               ping_log [$];

  // the responders answer pings, the tests add acknowledges of their own
  assign ack_i = resp_ack | inject_ack;

  ping_subsys_top u_ping_subsys_top (
    .clk_i              (clk_i),
    .rst_ni             (rst_ni),
    .en_i               (en_i),
    .clr_i              (clr_i),
    .edn_ack_i          (edn_ack_i),
    .edn_data_i         (edn_data_i),
    .alert_ping_en_i    (alert_ping_en_i),
    .ping_timeout_cyc_i (ping_timeout_cyc_i),
    .wait_cyc_mask_i    (wait_cyc_mask_i),
    .ack_i              (ack_i),
    .edn_req_o          (edn_req_o),
    .ping_o             (ping_o),
    .alert_fail_o       (alert_fail_o),
    .esc_fail_o         (esc_fail_o),
    .spurious_o         (spurious_o),
    .fsm_err_o          (fsm_err_o)
  );

  initial clk_i = 1'b0;
  always #(Period / 2) clk_i = ~clk_i;

  ////////////////////////////////////////
  // responder models
  ////////////////////////////////////////

  // each enabled channel answers its ping strobe resp_dly cycles later
  always @(negedge clk_i) begin
    for (int i = 0; i < NChan; i++) begin
      resp_ack[i] = 1'b0;
      if (!rst_ni) begin
        resp_cnt[i] = 0;
      end else begin
        if (resp_cnt[i] > 0) begin
          resp_cnt[i] = resp_cnt[i] - 1;
          if (resp_cnt[i] == 0) begin
            resp_ack[i] = 1'b1;
          end
        end
        if (ping_o[i] && resp_on[i]) begin
          resp_cnt[i] = resp_dly;
        end
      end
    end
  end

  // entropy source, one word per request
  always @(negedge clk_i) begin
    if (rst_ni && edn_en && edn_req_o && !edn_ack_i) begin
      edn_ack_i  = 1'b1;
      edn_data_i = $random(seed);
    end else begin
      edn_ack_i = 1'b0;
    end
  end

  // log every ping and make sure two channels never ping at once
  always @(negedge clk_i) begin
    if (rst_ni && ping_o != '0) begin
      checks++;
      assert ((ping_o & (ping_o - 1'b1)) == '0) else begin
        errors++;
        $display("error at %0t: several ping_o bits high together (%b)", $time, ping_o);
      end
      for (int i = 0; i < NChan; i++) begin
        if (ping_o[i]) begin
          ping_log.push_back(i);
        end
      end
    end
  end

  initial begin
    #(WatchdogCycles * Period);
    $display("timeout: the tests did not finish within %0d cycles", WatchdogCycles);
    $display("sim failed");
    $finish;
  end

  ////////////////////////////////////////
  // helpers
  ////////////////////////////////////////

  task automatic compare_value(string name, int got, int exp);
    checks++;
    assert (got == exp) else begin
      errors++;
      $display("mismatch at %0t: %s is %0d, expected %0d", $time, name, got, exp);
    end
  endtask

  task automatic confirm(bit cond, string what);
    checks++;
    assert (cond) else begin
      errors++;
      $display("error at %0t: %s", $time, what);
    end
  endtask

  task automatic apply_reset();
    @(negedge clk_i);
    rst_ni     = 1'b0;
    en_i       = 1'b0;
    clr_i      = 1'b0;
    inject_ack = '0;
    repeat (3) @(negedge clk_i);
    rst_ni = 1'b1;
    ping_log.delete();
  endtask

  // the log is filled at the falling edge, so it is read at the rising one
  task automatic wait_for_pings(int n);
    int cycles;
    cycles = 0;
    while (ping_log.size() < n && cycles < 2 * n * PingCycles) begin
      @(posedge clk_i);
      cycles++;
    end
    confirm(ping_log.size() >= n,
            $sformatf("only %0d of %0d pings seen in time", ping_log.size(), n));
  endtask

  task automatic flags_clear();
    @(negedge clk_i);
    compare_value("alert_fail_o", alert_fail_o, 0);
    compare_value("esc_fail_o", esc_fail_o, 0);
    compare_value("spurious_o", spurious_o, 0);
    compare_value("fsm_err_o", fsm_err_o, 0);
  endtask

  task automatic report_test(string name, int err_before);
    tests++;
    if (errors == err_before) begin
      $display("%s: ok", name);
    end else begin
      $display("%s: %0d errors", name, errors - err_before);
    end
  endtask

  ////////////////////////////////////////
  // tests
  ////////////////////////////////////////

  task automatic reset_reseed_test();
    int err_before;
    int cycles;
    err_before = errors;
    edn_en     = 1'b0;
    apply_reset();
    // the reseed timer comes out of reset at zero, so a request is pending
    repeat (10) begin
      @(negedge clk_i);
      compare_value("ping_o", ping_o, 0);
      compare_value("edn_req_o", edn_req_o, 1);
    end
    edn_en = 1'b1;
    cycles = 0;
    while (!edn_ack_i && cycles < 10) begin
      @(posedge clk_i);
      cycles++;
    end
    confirm(edn_ack_i, "the entropy request was never acknowledged");
    @(negedge clk_i);
    compare_value("edn_req_o", edn_req_o, 0);
    report_test("reset and reseed", err_before);
  endtask

  task automatic round_robin_test();
    int err_before;
    int esc_seen;
    err_before      = errors;
    resp_on         = '1;
    alert_ping_en_i = 4'b1111;
    apply_reset();
    en_i = 1'b1;
    wait_for_pings(12);
    esc_seen = 0;
    // alert and escalation pings take turns, escalations in fixed order
    for (int k = 0; k < 12; k++) begin
      if (k % 2 == 0) begin
        confirm(ping_log[k] < NAlerts,
                $sformatf("ping %0d went to channel %0d, not an alert", k, ping_log[k]));
      end else begin
        compare_value("escalation ping channel", ping_log[k], NAlerts + esc_seen % NEscSev);
        esc_seen++;
      end
    end
    flags_clear();
    report_test("round robin", err_before);
  endtask

  task automatic alert_mask_test();
    int err_before;
    int alerts;
    err_before      = errors;
    resp_on         = '1;
    alert_ping_en_i = 4'b0101;
    apply_reset();
    en_i = 1'b1;
    wait_for_pings(16);
    alerts = 0;
    for (int k = 0; k < 16; k++) begin
      confirm(ping_log[k] != 1 && ping_log[k] != 3,
              $sformatf("ping on disabled alert channel %0d", ping_log[k]));
      if (ping_log[k] < NAlerts) begin
        alerts++;
      end
    end
    confirm(alerts > 0, "no alert ping seen on the enabled channels");
    flags_clear();
    report_test("alert mask", err_before);
  endtask

  task automatic esc_timeout_test();
    int err_before;
    int cycles;
    err_before      = errors;
    resp_on         = 8'h0f;
    alert_ping_en_i = 4'b1111;
    apply_reset();
    en_i   = 1'b1;
    cycles = 0;
    while (!esc_fail_o && cycles < 4 * PingCycles) begin
      @(negedge clk_i);
      cycles++;
    end
    confirm(esc_fail_o, "esc_fail_o never rose with silent escalation channels");
    compare_value("alert_fail_o", alert_fail_o, 0);
    compare_value("fsm_err_o", fsm_err_o, 0);
    clr_i = 1'b1;
    @(negedge clk_i);
    clr_i = 1'b0;
    compare_value("esc_fail_o", esc_fail_o, 0);
    report_test("escalation timeout", err_before);
  endtask

  task automatic spurious_ack_test();
    int err_before;
    err_before = errors;
    resp_on    = '1;
    apply_reset();
    // the timer is still idle, so no channel has a ping outstanding
    @(negedge clk_i);
    inject_ack = 8'h20;
    @(negedge clk_i);
    inject_ack = '0;
    @(negedge clk_i);
    compare_value("spurious_o", spurious_o, 1);
    clr_i = 1'b1;
    @(negedge clk_i);
    clr_i = 1'b0;
    compare_value("spurious_o", spurious_o, 0);
    en_i = 1'b1;
    wait_for_pings(4);
    flags_clear();
    report_test("spurious acknowledge", err_before);
  endtask

  initial begin
    seed               = 32'h770becf5;
    errors             = 0;
    checks             = 0;
    tests              = 0;
    rst_ni             = 1'b0;
    en_i               = 1'b0;
    clr_i              = 1'b0;
    alert_ping_en_i    = '1;
    ping_timeout_cyc_i = ping_cnt_t'(Timeout);
    wait_cyc_mask_i    = 16'h000f;
    inject_ack         = '0;
    resp_on            = '1;
    resp_dly           = 2;
    edn_en             = 1'b0;

    reset_reseed_test();
    round_robin_test();
    alert_mask_test();
    esc_timeout_test();
    spurious_ack_test();

    $display("tests: %0d, checks: %0d, errors: %0d", tests, checks, errors);
    if (errors == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* src.f */
ping_cfg_pkg.sv
ping_fsm_pkg.sv
ping_lfsr.sv
ping_timer.sv
ping_chan.sv
ping_fail_status.sv
ping_subsys_top.sv
tb_ping_subsys.sv
